//--- sim/edit_trace.txt
# K code col row : key code in hex, cursor column and row in decimal
# E col row char : expected character in hex at that cell after the last refresh
K 41 0 0
K 42 0 0
K 43 1 0
K 05 3 0
K 7f 0 0
K 58 44 0
K 59 44 0
K 5a 44 21
K 51 43 21
K 52 44 21
K 7f 43 21
K 7f 44 0
K 0a 10 5
K 7f 44 21
K 7e 1 0
E 0 0 43
E 1 0 7e
E 2 0 41
E 3 0 20
E 44 0 20
E 0 1 58
E 1 1 20
E 10 5 20
E 42 21 20
E 43 21 52
E 44 21 20

//--- src.f
+incdir+rtl
rtl/text_pkg.sv
rtl/char_ram.sv
rtl/cell_walker.sv
rtl/edit_control.sv
rtl/text_buffer_top.sv
sim/clock_gen.sv
sim/tb_text_buffer.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the text buffer testbench, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_text_buffer -f src.f \
	-o tb_text_buffer > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_text_buffer > sim.log 2>&1
cat sim.log
grep -q "Test FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Test OK" sim.log && echo "simulation passed" || { echo "simulation did not finish"; exit 1; }

//--- sim/tb_text_buffer.sv
`timescale 1ns/1ps
`include "text_defines.svh"

module tb_text_buffer;
	import text_pkg::*;

	localparam int cells = `TEXT_COLS * `TEXT_ROWS;
	localparam int go_limit = 4000; // Insert at cell 0 is the longest edit
	localparam int ready_limit = 16;
	localparam int reset_limit = 20;

	logic clock;
	logic reset;
	logic key_valid;
	key_event_t key;
	logic key_ready;
	logic disp_go;
	disp_cell_t disp;
	logic disp_done;

	ascii_t model [0:cells-1]; // Expected screen
	ascii_t shown [0:cells-1]; // Screen as sent by the last refresh
	logic [31:0] lfsr;

	clock_gen u_clock_gen
	(
		.clock(clock),
		.reset(reset)
	);

	text_buffer_top UUT
	(
		.clock(clock),
		.reset(reset),
		.key_valid(key_valid),
		.key(key),
		.key_ready(key_ready),
		.disp_go(disp_go),
		.disp(disp),
		.disp_done(disp_done)
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic report_failure();
		$display("Test FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want)
		begin
			$display("mismatch at time %0t: %s is %0h, expected %0h", $time, name, got, want);
			report_failure();
		end
	endtask

	// Three LFSR bits give a delay of 0 to 7 cycles
	task automatic pick_delay(output int delay);
		int i;
		delay = 0;
		for (i = 0; i < 3; i++)
		begin
			lfsr = lfsr_step(lfsr);
			delay = (delay << 1) | int'(lfsr[0]);
		end
	endtask

	// Insert and delete rules, returns 1 when a refresh follows
	function automatic bit update_model(input ascii_t code, input int at);
		int i;
		if ((code >= `PRINT_LO) && (code <= `PRINT_HI))
		begin
			for (i = cells - 1; i > at; i--)
				model[i] = model[i-1]; // Last cell falls off
			model[at] = code;
			return 1'b1;
		end
		if (code == `CHAR_DEL)
		begin
			for (i = at; i < cells - 1; i++)
				model[i] = model[i+1];
			model[cells-1] = `CHAR_SPACE;
			return 1'b1;
		end
		return 1'b0;
	endfunction

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (reset !== 1'b1)
		begin
			@(negedge clock);
			cycles++;
			if (cycles > reset_limit)
			begin
				$display("timeout: reset was never released");
				report_failure();
			end
		end
	endtask

	task automatic wait_key_ready();
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (key_ready !== 1'b1)
		begin
			check_value("disp_go", disp_go, 0); // No refresh is due here
			cycles++;
			if (cycles > ready_limit)
			begin
				$display("timeout: key_ready stayed low for %0d cycles", ready_limit);
				report_failure();
			end
			@(negedge clock);
		end
	endtask

	task automatic wait_disp_go();
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (disp_go !== 1'b1)
		begin
			check_value("key_ready", key_ready, 0);
			cycles++;
			if (cycles > go_limit)
			begin
				$display("timeout: no disp_go within %0d cycles", go_limit);
				report_failure();
			end
			@(negedge clock);
		end
	endtask

	// Display side, takes all cells of one refresh in row-major order
	task automatic receive_refresh();
		int idx;
		int delay;
		int k;
		for (idx = 0; idx < cells; idx++)
		begin
			wait_disp_go();
			check_value("disp.ch", disp.ch, model[idx]);
			check_value("disp.x", disp.x, (idx % `TEXT_COLS) * `GLYPH_W);
			check_value("disp.y", disp.y, (idx / `TEXT_COLS) * `GLYPH_H);
			shown[idx] = disp.ch;
			pick_delay(delay);
			for (k = 0; k < delay; k++)
			begin
				@(negedge clock);
				check_value("disp_go", disp_go, 0); // Next cell waits for disp_done
			end
			@(posedge clock);
			disp_done <= 1'b1;
			@(posedge clock);
			disp_done <= 1'b0;
		end
	endtask

	task automatic send_key(input ascii_t code, input int col, input int row);
		key_event_t ev;
		ev.code = code;
		ev.pos.col = `COL_W'(col);
		ev.pos.row = `ROW_W'(row);
		wait_key_ready();
		@(posedge clock);
		key_valid <= 1'b1;
		key <= ev;
		@(posedge clock); // Taken here
		key_valid <= 1'b0;
		@(negedge clock);
		check_value("key_ready", key_ready, 0);
	endtask

	task automatic run_key(input ascii_t code, input int col, input int row);
		bit refresh;
		refresh = update_model(code, row * `TEXT_COLS + col);
		send_key(code, col, row);
		if (refresh)
			receive_refresh();
		else
			wait_key_ready(); // Ignored code returns to idle
	endtask

	initial
	begin
		int fd;
		int n;
		int i;
		string line;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		key_valid = 1'b0;
		key = '0;
		disp_done = 1'b0;
		lfsr = 32'h4f7997c6;
		for (i = 0; i < cells; i++)
			model[i] = `CHAR_SPACE;
		wait_reset_release();
		receive_refresh(); // Blank screen after the clear sweep
		fd = $fopen("sim/edit_trace.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open sim/edit_trace.txt");
			report_failure();
		end
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			if (n == 0)
				break; // End of the trace
			if ($sscanf(line, "K %h %d %d", a, b, c) == 3)
				run_key(a[6:0], b, c);
			else if ($sscanf(line, "E %d %d %h", a, b, c) == 3)
				check_value($sformatf("cell(%0d,%0d)", a, b), shown[b * `TEXT_COLS + a], c);
		end
		$fclose(fd);
		$display("Test OK");
		$finish;
	end

endmodule

//--- sim/clock_gen.sv
`timescale 1ns/1ps

module clock_gen
(
	output logic clock,
	output logic reset
);
	initial
	begin
		clock = 1'b0;
		reset = 1'b0; // Active low, held for 10 cycles
		repeat (10) @(posedge clock);
		reset <= 1'b1;
	end

	always #50 clock = ~clock; // 100 ns period

endmodule

//--- rtl/text_buffer_top.sv
`timescale 1ns/1ps

module text_buffer_top
(
	input logic clock,
	input logic reset,
	input logic key_valid,
	input text_pkg::key_event_t key,
	output logic key_ready,
	output logic disp_go,
	output text_pkg::disp_cell_t disp,
	input logic disp_done
);
	import text_pkg::*;

	walk_cmd_t walk_cmd;
	cell_pos_t load_pos;
	cell_pos_t pos; // Also the RAM address
	logic at_first;
	logic at_last;
	logic rd_en;
	logic wr_en;
	ascii_t wr_data;
	ascii_t rd_data;

	edit_control u_edit_control
	(
		.clock(clock),
		.reset(reset),
		.key_valid(key_valid),
		.key(key),
		.key_ready(key_ready),
		.walk_cmd(walk_cmd),
		.load_pos(load_pos),
		.pos(pos),
		.at_first(at_first),
		.at_last(at_last),
		.rd_en(rd_en),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.rd_data(rd_data),
		.disp_go(disp_go),
		.disp(disp),
		.disp_done(disp_done)
	);

	cell_walker u_cell_walker
	(
		.clock(clock),
		.reset(reset),
		.walk_cmd(walk_cmd),
		.load_pos(load_pos),
		.pos(pos),
		.at_first(at_first),
		.at_last(at_last)
	);

	char_ram u_char_ram
	(
		.clock(clock),
		.addr(pos),
		.rd_en(rd_en),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.rd_data(rd_data)
	);

endmodule

//--- rtl/edit_control.sv
`timescale 1ns/1ps
`include "text_defines.svh"

module edit_control
(
	input logic clock,
	input logic reset,
	input logic key_valid,
	input text_pkg::key_event_t key,
	output logic key_ready,
	output text_pkg::walk_cmd_t walk_cmd,
	output text_pkg::cell_pos_t load_pos,
	input text_pkg::cell_pos_t pos,
	input logic at_first,
	input logic at_last,
	output logic rd_en,
	output logic wr_en,
	output text_pkg::ascii_t wr_data,
	input text_pkg::ascii_t rd_data,
	output logic disp_go,
	output text_pkg::disp_cell_t disp,
	input logic disp_done
);
	import text_pkg::*;

	typedef enum logic [4:0]
	{
		s_clr_start,
		s_clear,
		s_idle,
		s_check,
		s_ins_prep,
		s_ins_read,
		s_ins_write,
		s_ins_key,
		s_del_prep,
		s_del_read,
		s_del_write,
		s_del_last,
		s_rf_start,
		s_rf_prep,
		s_rf_read,
		s_rf_go,
		s_rf_wait
	} state_t;

	localparam cell_pos_t first_cell = '0;
	localparam cell_pos_t last_cell = '{col: `COL_W'(`TEXT_COLS - 1), row: `ROW_W'(`TEXT_ROWS - 1)};
	localparam logic [`PIX_W-1:0] glyph_w = `PIX_W'(`GLYPH_W);
	localparam logic [`PIX_W-1:0] glyph_h = `PIX_W'(`GLYPH_H);

	state_t state;
	state_t next_state;
	key_event_t key_reg;
	logic is_print;
	logic is_del;
	logic go_pending;

	assign key_ready = (state == s_idle);

	// Accepted keystroke
	always_ff @(posedge clock)
	begin
		if (key_valid && key_ready)
			key_reg <= key;
	end

	assign is_print = (key_reg.code >= `PRINT_LO) && (key_reg.code <= `PRINT_HI);
	assign is_del = (key_reg.code == `CHAR_DEL);

	// Display cell straight from the RAM output and the walker
	assign disp = '{ch: rd_data,
		x: `PIX_W'(pos.col) * glyph_w,
		y: `PIX_W'(pos.row) * glyph_h};

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
			state <= s_clr_start;
		else
			state <= next_state;
	end

	// Cell sent and not yet acknowledged by the display
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
			go_pending <= 1'b0;
		else if (disp_go)
			go_pending <= 1'b1;
		else if (disp_done)
			go_pending <= 1'b0;
	end

	always_comb
	begin
		next_state = state;
		walk_cmd = walk_hold;
		load_pos = first_cell;
		rd_en = 1'b0;
		wr_en = 1'b0;
		wr_data = rd_data; // Shift writes copy the cell just read
		disp_go = 1'b0;
		case (state)
			s_clr_start:
			begin
				walk_cmd = walk_load;
				next_state = s_clear;
			end
			s_clear:
			begin
				// One space per cycle
				wr_en = 1'b1;
				wr_data = `CHAR_SPACE;
				if (at_last)
					next_state = s_rf_start;
				else
					walk_cmd = walk_fwd;
			end
			s_idle:
			begin
				if (key_valid)
					next_state = s_check;
			end
			s_check:
			begin
				if (is_print)
				begin
					// Insert shifts from the end back toward the cursor
					walk_cmd = walk_load;
					load_pos = last_cell;
					next_state = s_ins_prep;
				end
				else if (is_del)
				begin
					walk_cmd = walk_load;
					load_pos = key_reg.pos;
					next_state = s_del_prep;
				end
				else
					next_state = s_idle; // Ignored code, no refresh
			end
			s_ins_prep:
			begin
				if ((pos == key_reg.pos) || at_first)
					next_state = s_ins_key;
				else
				begin
					walk_cmd = walk_back; // Go to previous cell
					next_state = s_ins_read;
				end
			end
			s_ins_read:
			begin
				rd_en = 1'b1;
				walk_cmd = walk_fwd;
				next_state = s_ins_write;
			end
			s_ins_write:
			begin
				wr_en = 1'b1;
				walk_cmd = walk_back;
				next_state = s_ins_prep;
			end
			s_ins_key:
			begin
				wr_en = 1'b1;
				wr_data = key_reg.code;
				next_state = s_rf_start;
			end
			s_del_prep:
			begin
				if (at_last)
					next_state = s_del_last;
				else
				begin
					walk_cmd = walk_fwd; // Go to next cell
					next_state = s_del_read;
				end
			end
			s_del_read:
			begin
				rd_en = 1'b1;
				walk_cmd = walk_back;
				next_state = s_del_write;
			end
			s_del_write:
			begin
				wr_en = 1'b1;
				walk_cmd = walk_fwd;
				next_state = s_del_prep;
			end
			s_del_last:
			begin
				wr_en = 1'b1;
				wr_data = `CHAR_SPACE; // Fill the vacated last cell
				next_state = s_rf_start;
			end
			s_rf_start:
			begin
				walk_cmd = walk_load;
				next_state = s_rf_read;
			end
			s_rf_prep:
			begin
				walk_cmd = walk_fwd;
				next_state = s_rf_read;
			end
			s_rf_read:
			begin
				rd_en = 1'b1;
				next_state = s_rf_go;
			end
			s_rf_go:
			begin
				disp_go = 1'b1;
				next_state = s_rf_wait;
			end
			s_rf_wait:
			begin
				// Display sets the pace
				if (disp_done)
					next_state = at_last ? s_idle : s_rf_prep;
			end
			default: next_state = s_idle;
		endcase
	end

	// No second disp_go until the display answers, so never two in a row
	assert property (@(posedge clock) disable iff (!reset) go_pending |-> !disp_go)
		else $error("edit_control: disp_go repeated before disp_done");

endmodule

//--- rtl/cell_walker.sv
`timescale 1ns/1ps
`include "text_defines.svh"

module cell_walker
(
	input logic clock,
	input logic reset,
	input text_pkg::walk_cmd_t walk_cmd,
	input text_pkg::cell_pos_t load_pos,
	output text_pkg::cell_pos_t pos,
	output logic at_first,
	output logic at_last
);
	import text_pkg::*;

	localparam logic [`COL_W-1:0] last_col = `COL_W'(`TEXT_COLS - 1);
	localparam logic [`ROW_W-1:0] last_row = `ROW_W'(`TEXT_ROWS - 1);

	cell_pos_t next_pos;

	assign at_first = (pos == '0);
	assign at_last = (pos.col == last_col) && (pos.row == last_row);

	// Row-major stepping
	always_comb
	begin
		next_pos = pos;
		case (walk_cmd)
			walk_load: next_pos = load_pos;
			walk_fwd:
			begin
				if (at_last)
					next_pos = pos; // Clamp at bottom right
				else if (pos.col == last_col)
				begin
					// Wrap to start of next row
					next_pos.col = '0;
					next_pos.row = pos.row + 1'b1;
				end
				else
					next_pos.col = pos.col + 1'b1;
			end
			walk_back:
			begin
				if (at_first)
					next_pos = pos; // Clamp at top left
				else if (pos.col == '0)
				begin
					next_pos.col = last_col; // End of previous row
					next_pos.row = pos.row - 1'b1;
				end
				else
					next_pos.col = pos.col - 1'b1;
			end
			default: next_pos = pos;
		endcase
	end

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
			pos <= '0;
		else
			pos <= next_pos;
	end

	// Loaded cursor positions must also be on screen
	assert property (@(posedge clock) disable iff (!reset)
		(pos.col < `TEXT_COLS) && (pos.row < `TEXT_ROWS))
		else $error("cell_walker: position off screen");

endmodule

//--- rtl/char_ram.sv
`timescale 1ns/1ps
`include "text_defines.svh"

module char_ram
(
	input logic clock,
	input text_pkg::cell_pos_t addr,
	input logic rd_en,
	input logic wr_en,
	input text_pkg::ascii_t wr_data,
	output text_pkg::ascii_t rd_data
);
	import text_pkg::*;

	// 2048 words, only 45 x 22 of them are used
	ascii_t mem [0:(1 << `ADDR_W) - 1];

	always_ff @(posedge clock)
	begin
		if (wr_en)
			mem[addr] <= wr_data;
	end

	// Read data stays put until the next read
	always_ff @(posedge clock)
	begin
		if (rd_en)
			rd_data <= mem[addr];
	end

	// Single port, the controller must never ask for both at once
	assert property (@(posedge clock) !(rd_en && wr_en))
		else $error("char_ram: read and write in the same cycle");

endmodule

//--- rtl/text_pkg.sv
`include "text_defines.svh"

package text_pkg;

	// One stored character
	typedef logic [`CHAR_W-1:0] ascii_t;

	// Column sits in the upper bits so the struct is the RAM address as is
	typedef struct packed
	{
		logic [`COL_W-1:0] col;
		logic [`ROW_W-1:0] row;
	} cell_pos_t;

	// Keystroke with the cursor cell it applies to
	typedef struct packed
	{
		ascii_t code;
		cell_pos_t pos;
	} key_event_t;

	// Character for the display at its pixel origin
	typedef struct packed
	{
		ascii_t ch;
		logic [`PIX_W-1:0] x;
		logic [`PIX_W-1:0] y;
	} disp_cell_t;

	typedef enum logic [1:0]
	{
		walk_hold,
		walk_load,
		walk_fwd,
		walk_back
	} walk_cmd_t;

endpackage

//--- rtl/text_defines.svh
`ifndef TEXT_DEFINES_SVH
`define TEXT_DEFINES_SVH

// Screen geometry in cells
`define TEXT_COLS 45
`define TEXT_ROWS 22
`define COL_W 6
`define ROW_W 5
`define ADDR_W 11 // {col, row}

// Character and glyph sizes
`define CHAR_W 7
`define GLYPH_W 7 // Pixels per column
`define GLYPH_H 10 // Pixels per row
`define PIX_W 9

// Special codes
`define CHAR_SPACE 7'h20
`define CHAR_DEL 7'h7F
`define PRINT_LO 7'h20
`define PRINT_HI 7'h7E

`endif
